/* Bender.yml */
package:
  name: mips_lsu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_lsu_pkg.sv
      - verilog/instr_decoder.sv
      - verilog/cycle_sequencer.sv
      - verilog/load_store.sv
      - verilog/reg_file.sv
      - verilog/mips_lsu_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_clk_gen.sv
      - sim/mips_lsu_chk.sv
      - sim/mips_lsu_tb.sv

/* all.f */
+incdir+verilog
verilog/mips_lsu_pkg.sv
verilog/instr_decoder.sv
verilog/cycle_sequencer.sv
verilog/load_store.sv
verilog/reg_file.sv
verilog/mips_lsu_top.sv
sim/tb_clk_gen.sv
sim/mips_lsu_chk.sv
sim/mips_lsu_tb.sv

/* sim/mips_lsu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_lsu_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     waitrequest,
    input logic [31:0]              mem_address,
    input logic [3:0]               mem_byteenable,
    input logic [31:0]              mem_writedata,
    input logic                     mem_read,
    input logic                     mem_write,
    input mips_lsu_pkg::cpu_state_e state
);
    import mips_lsu_pkg::*;

    int unsigned fail_count = 0;    // Read by the testbench at the end

    a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high in the same cycle");
            fail_count++;
        end

    // Stalled request keeps every bus field
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) && waitrequest |=>
            $stable(mem_read) && $stable(mem_write) && $stable(mem_address) &&
            $stable(mem_byteenable) && $stable(mem_writedata))
        else begin
            $error("Request changed while waitrequest was high");
            fail_count++;
        end

    a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) |-> (mem_byteenable != 4'b0000))
        else begin
            $error("Active request with all byte enables low");
            fail_count++;
        end

    a_write_state: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write |-> (state == ST_EXEC1))
        else begin
            $error("mem_write high outside ST_EXEC1");
            fail_count++;
        end

endmodule

`default_nettype wire

/* sim/mips_lsu_tb.sv */
`timescale 1ns/1ps
`include "mips_lsu_settings.svh"
`default_nettype none

module mips_lsu_tb;
    import mips_lsu_pkg::*;

    localparam int          WAIT_LIMIT = 20000;    // Cycles for the whole program
    localparam logic [31:0] DATA_BASE  = 32'h0000_0800;
    localparam logic [31:0] STORE_BASE = 32'h0000_0c00;

    logic        clk;
    logic        rst_n;
    logic [31:0] mem_readdata = 32'h0000_0000;
    logic        waitrequest  = 1'b1;
    logic [31:0] mem_address;
    logic [3:0]  mem_byteenable;
    logic [31:0] mem_writedata;
    logic        mem_read;
    logic        mem_write;

    logic [31:0] mem [1024];                    // Memory seen by the DUT
    logic [31:0] dm [1024];                     // Expected data memory
    logic [31:0] rm [`MIPS_LSU_NUM_REGS];       // Expected register file
    integer      seed = 32'h13d7a35c;
    int          prog_word;
    logic [31:0] store_ptr;

    string       exp_name [$];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_be [$];
    logic [31:0] exp_data [$];

    int pass_count;
    int fail_count;
    bit test_failed;
    bit timed_out;
    int cycles;

    // Bus state taken mid-cycle, where every output has settled
    logic        s_rst_n;
    logic        s_read;
    logic        s_write;
    logic [31:0] s_addr;
    logic [3:0]  s_be;
    logic [31:0] s_wdata;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    mips_lsu_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_readdata   (mem_readdata),
        .waitrequest    (waitrequest),
        .mem_address    (mem_address),
        .mem_byteenable (mem_byteenable),
        .mem_writedata  (mem_writedata),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    bind mips_lsu_top mips_lsu_chk u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .waitrequest    (waitrequest),
        .mem_address    (mem_address),
        .mem_byteenable (mem_byteenable),
        .mem_writedata  (mem_writedata),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .state          (state)
    );

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    // Expected rt after a load of word at byte offset lane
    function automatic logic [31:0] expected_load(input mem_op_e op, input logic [31:0] word,
                                                  input logic [1:0] lane,
                                                  input logic [31:0] old);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] r;
        b = word >> (8 * lane);
        h = word >> (16 * lane[1]);
        r = old;
        case (op)
            OP_LB:  r = {{24{b[7]}}, b};
            OP_LBU: r = {24'h00_0000, b};
            OP_LH:  r = {{16{h[15]}}, h};
            OP_LHU: r = {16'h0000, h};
            OP_LW:  r = word;
            OP_LWL: begin
                for (int i = 0; i < 4; i++) begin
                    if (i >= lane) r[8*i +: 8] = word[8*(i - lane) +: 8];    // Top bytes
                end
            end
            OP_LWR: begin
                for (int i = 0; i < 4; i++) begin
                    if (i <= lane) r[8*i +: 8] = word[8*(i + 3 - lane) +: 8];
                end
            end
            default: r = old;
        endcase
        return r;
    endfunction

    task automatic emit(input mem_op_e op, input logic [4:0] rt, input logic [15:0] imm);
        mem[prog_word] = {op, 5'd0, rt, imm};    // Base is always r0
        prog_word++;
    endtask

    task automatic emit_load(input mem_op_e op, input logic [4:0] rt, input logic [31:0] addr);
        emit(op, rt, addr[15:0]);
        if (rt != 5'd0) rm[rt] = expected_load(op, dm[addr[11:2]], addr[1:0], rm[rt]);
    endtask

    task automatic emit_lui(input logic [4:0] rt, input logic [15:0] imm);
        emit(OP_LUI, rt, imm);
        if (rt != 5'd0) rm[rt] = {imm, 16'h0000};
    endtask

    // Each store goes to a fresh word and queues the expected bus write
    task automatic emit_store(input mem_op_e op, input logic [4:0] rt, input logic [1:0] lane,
                              input string name);
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
        int          size;
        addr = store_ptr + lane;
        store_ptr = store_ptr + 32'd4;
        case (op)
            OP_SB:   size = 1;
            OP_SH:   size = 2;
            default: size = 4;
        endcase
        // Low bytes of rt fill the aligned group of size bytes that holds lane
        for (int i = 0; i < 4; i++) begin
            be[i]          = ((i / size) == (lane / size));
            data[8*i +: 8] = rm[rt][8*(i % size) +: 8];
        end
        emit(op, rt, addr[15:0]);
        exp_name.push_back(name);
        exp_addr.push_back({addr[31:2], 2'b00});
        exp_be.push_back(be);
        exp_data.push_back(data);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) dm[addr[11:2]][8*i +: 8] = data[8*i +: 8];
        end
    endtask

    task automatic build_program();
        logic [31:0] w;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h0000_0000;
            dm[i]  = 32'h0000_0000;
        end
        for (int i = 0; i < `MIPS_LSU_NUM_REGS; i++) begin
            rm[i] = 32'h0000_0000;
        end
        prog_word = `MIPS_LSU_RESET_PC >> 2;
        store_ptr = STORE_BASE;
        for (int i = 0; i < 8; i++) begin
            w = $random(seed);
            if (i == 1) w = (w & 32'h7f7f_7f7f) | 32'h8000_8000;    // Bytes 1 and 3 negative
            if (i == 2) w = (w & 32'h7fff_7fff) | 32'h0000_8000;    // Low half negative
            mem[(DATA_BASE >> 2) + i] = w;
            dm[(DATA_BASE >> 2) + i]  = w;
        end
        emit_load(OP_LW, 5'd1, DATA_BASE);
        emit_store(OP_SW, 5'd1, 2'd0, "lw_sw");
        for (int k = 0; k < 4; k++) begin
            emit_load(OP_LB, 5'd2, DATA_BASE + 4 + k);
            emit_store(OP_SW, 5'd2, 2'd0, $sformatf("lb_off%0d", k));
            emit_load(OP_LBU, 5'd3, DATA_BASE + 4 + k);
            emit_store(OP_SW, 5'd3, 2'd0, $sformatf("lbu_off%0d", k));
        end
        for (int k = 0; k < 4; k += 2) begin
            emit_load(OP_LH, 5'd4, DATA_BASE + 8 + k);
            emit_store(OP_SW, 5'd4, 2'd0, $sformatf("lh_off%0d", k));
            emit_load(OP_LHU, 5'd5, DATA_BASE + 8 + k);
            emit_store(OP_SW, 5'd5, 2'd0, $sformatf("lhu_off%0d", k));
        end
        emit_load(OP_LW, 5'd6, DATA_BASE + 12);
        for (int k = 0; k < 4; k++) begin
            emit_store(OP_SB, 5'd6, 2'(k), $sformatf("sb_off%0d", k));
        end
        emit_store(OP_SH, 5'd6, 2'd0, "sh_off0");
        emit_store(OP_SH, 5'd6, 2'd2, "sh_off2");
        emit_lui(5'd7, 16'ha5c3);
        emit_store(OP_SW, 5'd7, 2'd0, "lui_sw");
        for (int k = 0; k < 4; k++) begin
            emit_lui(5'd8, 16'h5a00 + 16'(k));    // Upper bytes survive lwr
            emit_load(OP_LWR, 5'd8, DATA_BASE + 16 + k);
            emit_store(OP_SW, 5'd8, 2'd0, $sformatf("lwr_off%0d", k));
            emit_load(OP_LW, 5'd9, DATA_BASE + 20);    // Lower bytes survive lwl
            emit_load(OP_LWL, 5'd9, DATA_BASE + 24 + k);
            emit_store(OP_SW, 5'd9, 2'd0, $sformatf("lwl_off%0d", k));
        end
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic close_test(input string name, input string detail);
        if (test_failed) begin
            fail_count++;
        end else begin
            pass_count++;
            $display("ok     %s %s", name, detail);
        end
        test_failed = 1'b0;
    endtask

    always @(negedge clk) begin
        s_rst_n = rst_n;
        s_read  = mem_read;
        s_write = mem_write;
        s_addr  = mem_address;
        s_be    = mem_byteenable;
        s_wdata = mem_writedata;
    end

    // Memory model with one cycle of read latency
    always @(posedge clk) begin
        logic [31:0] rdata;
        rdata = mem_readdata;
        if (s_rst_n && !waitrequest) begin
            if (s_read) begin
                for (int i = 0; i < 4; i++) begin
                    // Lanes outside the byte enables come back unknown
                    rdata[8*i +: 8] = s_be[i] ? mem[s_addr[11:2]][8*i +: 8] : 8'hxx;
                end
            end
            if (s_write) begin
                for (int i = 0; i < 4; i++) begin
                    if (s_be[i]) mem[s_addr[11:2]][8*i +: 8] = s_wdata[8*i +: 8];
                end
            end
        end
        #1;
        mem_readdata = rdata;
        waitrequest  = s_rst_n ? (($random(seed) & 3) == 0) : 1'b1;
    end

    always @(posedge clk) begin
        string       name;
        logic [31:0] e_addr;
        logic [3:0]  e_be;
        logic [31:0] e_data;
        if (s_rst_n && s_write && !waitrequest) begin
            if (exp_addr.size() == 0) begin
                $display("Unexpected write to %h with no store pending", s_addr);
                fail_count++;
            end else begin
                name   = exp_name.pop_front();
                e_addr = exp_addr.pop_front();
                e_be   = exp_be.pop_front();
                e_data = exp_data.pop_front();
                compare({name, " address"}, e_addr, s_addr);
                compare({name, " byteenable"}, {28'h0, e_be}, {28'h0, s_be});
                compare({name, " data"}, e_data & lane_mask(e_be), s_wdata & lane_mask(e_be));
                close_test(name, $sformatf("addr %h be %b lanes %h", s_addr, s_be,
                                           s_wdata & lane_mask(s_be)));
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        test_failed = 1'b0;
        timed_out   = 1'b0;
        build_program();
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        compare("reset_fetch read", 32'd1, {31'd0, mem_read});
        compare("reset_fetch write", 32'd0, {31'd0, mem_write});
        compare("reset_fetch address", `MIPS_LSU_RESET_PC, mem_address);
        close_test("reset_fetch", $sformatf("addr %h", mem_address));
        cycles = 0;
        while (exp_addr.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = (exp_addr.size() != 0);
        if (timed_out) begin
            $display("Timed out after %0d cycles waiting for %0d stores from the DUT",
                     cycles, exp_addr.size());
        end
        $display("Tests passed %0d, failed %0d, assertion failures %0d",
                 pass_count, fail_count, UUT.u_chk.fail_count);
        if (!timed_out && fail_count == 0 && UUT.u_chk.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;    // 4 ns period

endmodule

`default_nettype wire

/* verilog/cycle_sequencer.sv */
`timescale 1ns/1ps
`include "mips_lsu_settings.svh"
`default_nettype none

module cycle_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     waitrequest,
    input  logic                     mem_access,
    output mips_lsu_pkg::cpu_state_e state,
    output logic [31:0]              pc
);
    import mips_lsu_pkg::*;

    cpu_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH: begin
                if (!waitrequest) begin
                    state_next = ST_DECODE;    // Fetch accepted
                end
            end
            ST_DECODE: begin
                state_next = ST_EXEC1;
            end
            ST_EXEC1: begin
                // Only a pending data request can be stalled
                if (!(mem_access && waitrequest)) begin
                    state_next = ST_EXEC2;
                end
            end
            default: begin
                state_next = ST_FETCH;    // ST_EXEC2 retires
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_FETCH;
            pc    <= `MIPS_LSU_RESET_PC;
        end else begin
            state <= state_next;
            if (state == ST_EXEC2) begin
                pc <= pc + 32'd4;    // Next sequential word
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mips_lsu_pkg::cpu_state_e state,
    input  logic [31:0]              mem_readdata,
    output mips_lsu_pkg::mem_op_e    op,
    output logic [4:0]               rs,
    output logic [4:0]               rt,
    output logic [15:0]              offset
);
    import mips_lsu_pkg::*;

    logic [31:0] ir;    // Instruction register

    // Fetch data returns one cycle after acceptance, i.e. during ST_DECODE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (state == ST_DECODE) begin
            ir <= mem_readdata;
        end
    end

    always_comb begin
        case (ir[31:26])
            OP_LB,
            OP_LH,
            OP_LWL,
            OP_LW,
            OP_LBU,
            OP_LHU,
            OP_LWR,
            OP_SB,
            OP_SH,
            OP_SW,
            OP_LUI: begin
                op = mem_op_e'(ir[31:26]);
            end
            default: begin
                op = OP_OTHER;    // Anything not handled here
            end
        endcase
    end

    assign rs     = ir[25:21];    // Base register
    assign rt     = ir[20:16];    // Load target or store source
    assign offset = ir[15:0];

endmodule

`default_nettype wire

/* verilog/load_store.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store (
    input  mips_lsu_pkg::cpu_state_e state,
    input  logic [31:0]              pc,
    input  mips_lsu_pkg::mem_op_e    op,
    input  logic [4:0]               rt,
    input  logic [15:0]              offset,
    input  logic [31:0]              rs_data,
    input  logic [31:0]              rt_data,
    input  logic [31:0]              mem_readdata,
    output logic [31:0]              mem_address,
    output logic [3:0]               mem_byteenable,
    output logic [31:0]              mem_writedata,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     mem_access,
    output logic                     reg_we,
    output logic [4:0]               reg_waddr,
    output logic [31:0]              reg_wdata
);
    import mips_lsu_pkg::*;

    logic [31:0] eff_addr;
    logic [1:0]  lane;
    logic        is_load;
    logic        is_store;
    logic [3:0]  op_mask;    // Lanes touched by the current op
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign eff_addr = rs_data + {{16{offset[15]}}, offset};
    assign lane     = eff_addr[1:0];

    assign mem_address = (state == ST_FETCH) ? pc : {eff_addr[31:2], 2'b00};

    assign is_load  = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    assign is_store = op inside {OP_SB, OP_SH, OP_SW};

    assign mem_access = (state == ST_EXEC1) && (is_load || is_store);
    assign mem_read   = (state == ST_FETCH) || ((state == ST_EXEC1) && is_load);
    assign mem_write  = (state == ST_EXEC1) && is_store;

    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: begin
                op_mask = 4'b0001 << lane;
            end
            OP_LH, OP_LHU, OP_SH: begin
                op_mask = lane[1] ? 4'b1100 : 4'b0011;
            end
            OP_LWL: begin
                op_mask = 4'b1111 >> lane;    // 1111, 0111, 0011, 0001
            end
            OP_LWR: begin
                op_mask = 4'b1111 << (2'd3 - lane);    // 1000, 1100, 1110, 1111
            end
            default: begin
                op_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        if (state == ST_FETCH) begin
            mem_byteenable = 4'b1111;    // Whole instruction word
        end else if (mem_access) begin
            mem_byteenable = op_mask;
        end else begin
            mem_byteenable = 4'b0000;
        end
    end

    // Narrow stores go out in the addressed lane only
    always_comb begin
        case (op)
            OP_SB:   mem_writedata = {24'h00_0000, rt_data[7:0]} << {lane, 3'b000};
            OP_SH:   mem_writedata = lane[1] ? {rt_data[15:0], 16'h0000}
                                             : {16'h0000, rt_data[15:0]};
            OP_SW:   mem_writedata = rt_data;
            default: mem_writedata = 32'h0000_0000;
        endcase
    end

    assign rd_byte = mem_readdata[{lane, 3'b000} +: 8];
    assign rd_half = mem_readdata[{lane[1], 4'b0000} +: 16];

    assign reg_we    = (state == ST_EXEC2) && (is_load || (op == OP_LUI));
    assign reg_waddr = rt;

    always_comb begin
        case (op)
            OP_LB:  reg_wdata = {{24{rd_byte[7]}}, rd_byte};
            OP_LBU: reg_wdata = {24'h00_0000, rd_byte};
            OP_LH:  reg_wdata = {{16{rd_half[15]}}, rd_half};
            OP_LHU: reg_wdata = {16'h0000, rd_half};
            OP_LW:  reg_wdata = mem_readdata;
            OP_LWL: begin
                // Low bytes of the word fill the top of rt
                case (lane)
                    2'd0:    reg_wdata = mem_readdata;
                    2'd1:    reg_wdata = {mem_readdata[23:0], rt_data[7:0]};
                    2'd2:    reg_wdata = {mem_readdata[15:0], rt_data[15:0]};
                    default: reg_wdata = {mem_readdata[7:0], rt_data[23:0]};
                endcase
            end
            OP_LWR: begin
                // High bytes of the word fill the bottom of rt
                case (lane)
                    2'd0:    reg_wdata = {rt_data[31:8], mem_readdata[31:24]};
                    2'd1:    reg_wdata = {rt_data[31:16], mem_readdata[31:16]};
                    2'd2:    reg_wdata = {rt_data[31:24], mem_readdata[31:8]};
                    default: reg_wdata = mem_readdata;
                endcase
            end
            OP_LUI:  reg_wdata = {offset, 16'h0000};
            default: reg_wdata = 32'h0000_0000;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/mips_lsu_pkg.sv */
`default_nettype none

package mips_lsu_pkg;

    // Phases of one instruction, no overlap between instructions
    typedef enum logic [1:0] {
        ST_FETCH  = 2'b00,
        ST_DECODE = 2'b01,
        ST_EXEC1  = 2'b10,
        ST_EXEC2  = 2'b11
    } cpu_state_e;

    // Values match the MIPS primary opcode field
    typedef enum logic [5:0] {
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LWL   = 6'h22,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_LWR   = 6'h26,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b,
        OP_OTHER = 6'h3f    // Retires with no effect
    } mem_op_e;

endpackage

`default_nettype wire

/* verilog/mips_lsu_settings.svh */
`default_nettype none

`ifndef MIPS_LSU_SETTINGS_SVH
`define MIPS_LSU_SETTINGS_SVH

// First fetch address after reset
`define MIPS_LSU_RESET_PC 32'h0000_0000

`define MIPS_LSU_NUM_REGS 32    // Architectural registers r0..r31
`define MIPS_LSU_DATA_W   32    // Register and bus word width

`endif

`default_nettype wire

/* verilog/mips_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_lsu_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] mem_readdata,
    input  logic        waitrequest,
    output logic [31:0] mem_address,
    output logic [3:0]  mem_byteenable,
    output logic [31:0] mem_writedata,
    output logic        mem_read,
    output logic        mem_write
);
    import mips_lsu_pkg::*;

    cpu_state_e  state;
    logic [31:0] pc;
    mem_op_e     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] offset;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        mem_access;    // Data request pending in ST_EXEC1
    logic        reg_we;
    logic [4:0]  reg_waddr;
    logic [31:0] reg_wdata;

    cycle_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .waitrequest (waitrequest),
        .mem_access  (mem_access),
        .state       (state),
        .pc          (pc)
    );

    instr_decoder u_dec (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .mem_readdata (mem_readdata),
        .op           (op),
        .rs           (rs),
        .rt           (rt),
        .offset       (offset)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .we      (reg_we),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // Drives the bus directly, fetch and data share one address port
    load_store u_lsu (
        .state          (state),
        .pc             (pc),
        .op             (op),
        .rt             (rt),
        .offset         (offset),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .mem_readdata   (mem_readdata),
        .mem_address    (mem_address),
        .mem_byteenable (mem_byteenable),
        .mem_writedata  (mem_writedata),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_access     (mem_access),
        .reg_we         (reg_we),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata)
    );

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`include "mips_lsu_settings.svh"
`default_nettype none

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [4:0]                  rs,
    input  logic [4:0]                  rt,
    input  logic                        we,
    input  logic [4:0]                  waddr,
    input  logic [`MIPS_LSU_DATA_W-1:0] wdata,
    output logic [`MIPS_LSU_DATA_W-1:0] rs_data,
    output logic [`MIPS_LSU_DATA_W-1:0] rt_data
);

    logic [`MIPS_LSU_DATA_W-1:0] regs [`MIPS_LSU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_LSU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;    // r0 stays zero
        end
    end

    // Combinational read, so EXEC stages see operands at once
    assign rs_data = (rs == 5'd0) ? '0 : regs[rs];
    assign rt_data = (rt == 5'd0) ? '0 : regs[rt];

endmodule

`default_nettype wire
